// ==== segre_defs.svh ====
`ifndef SEGRE_DEFS_SVH
`define SEGRE_DEFS_SVH

// byte address width
`define SEGRE_ADDR_SIZE 32
// data path width, one memory word
`define SEGRE_WORD_SIZE 32
// instruction id carried along with each access
`define SEGRE_ID_SIZE 4
// store buffer depth
`define SEGRE_SB_ENTRIES 2
// data memory depth in words
`define SEGRE_DMEM_WORDS 64

`endif

// ==== segre_pkg.sv ====
package segre_pkg;

`include "segre_defs.svh"

    // access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

    // request entering the memory stage
    typedef struct packed {
        logic                        is_store;
        memop_data_type_e            memop_data_type;
        logic [`SEGRE_ADDR_SIZE-1:0] addr;
        logic [`SEGRE_WORD_SIZE-1:0] data;
        logic [`SEGRE_ID_SIZE-1:0]   instr_id;
    } mem_req_t;

    // response leaving the stage, data is zero-extended and right-aligned
    typedef struct packed {
        logic                        is_store;
        logic [`SEGRE_ID_SIZE-1:0]   instr_id;
        logic [`SEGRE_WORD_SIZE-1:0] data;
        logic                        forwarded;
    } mem_rsp_t;

    // one word write from the store buffer into data memory
    typedef struct packed {
        logic [`SEGRE_ADDR_SIZE-3:0] word_addr;
        logic [3:0]                  be;
        logic [`SEGRE_WORD_SIZE-1:0] data;
    } sb_drain_t;

endpackage

// ==== segre_pipe_reg.sv ====
`timescale 1ns/100ps

module segre_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;

    // free slot, or the held item leaves on this edge
    assign in_ready_o = out_ready_i | ~full_q;

    // occupancy follows the upstream valid whenever a load is allowed
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    // payload only captured on a real transfer
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

// ==== segre_store_buffer.sv ====
`timescale 1ns/100ps
`include "segre_defs.svh"

module segre_store_buffer import segre_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        lookup_valid_i,
    input  logic                        is_store_i,
    input  logic                        commit_i,
    input  logic [`SEGRE_ADDR_SIZE-1:0] addr_i,
    input  logic [`SEGRE_WORD_SIZE-1:0] data_i,
    input  memop_data_type_e            memop_data_type_i,
    input  logic [`SEGRE_ID_SIZE-1:0]   instr_id_i,
    input  logic                        flush_chance_i,
    output logic                        hit_o,
    output logic                        full_o,
    output logic                        trouble_o,
    output logic [`SEGRE_WORD_SIZE-1:0] load_data_o,
    output logic                        drain_valid_o,
    output sb_drain_t                   drain_o
);

    localparam int ENTRIES = `SEGRE_SB_ENTRIES;
    localparam int PTR_W   = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    // buffered store, size is the one of the allocating store
    typedef struct packed {
        logic [`SEGRE_ADDR_SIZE-1:0] addr;
        memop_data_type_e            size;
        logic [3:0][7:0]             data;
        logic [3:0]                  be;
        logic [`SEGRE_ID_SIZE-1:0]   instr_id;
    } sb_entry_t;

    sb_entry_t [ENTRIES-1:0] entry_q;
    logic [ENTRIES-1:0]      valid_q;
    // head is the next free slot, tail the oldest entry
    logic [PTR_W-1:0]        head_q;
    logic [PTR_W-1:0]        tail_q;
    logic [ENTRIES-1:0]      hit_vec;
    logic [PTR_W-1:0]        hit_idx;
    logic                    hit;
    logic                    trouble;
    logic [3:0]              wr_be;
    logic [3:0][7:0]         wr_lanes;
    logic                    do_merge;
    logic                    do_alloc;
    logic                    do_drain;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // word address compare, at most one entry can match a word
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            hit_vec[i] = lookup_valid_i & valid_q[i] &
                (entry_q[i].addr[`SEGRE_ADDR_SIZE-1:2] == addr_i[`SEGRE_ADDR_SIZE-1:2]);
            if (hit_vec[i]) begin
                hit_idx = PTR_W'(i);
            end
        end
    end

    assign hit = |hit_vec;

    // overlap check against the hit entry
    always_comb begin
        trouble = 1'b0;
        if (hit) begin
            case (entry_q[hit_idx].size)
                // only the very same byte may touch a buffered byte
                BYTE: trouble = (memop_data_type_i != BYTE) ||
                                (entry_q[hit_idx].addr[1:0] != addr_i[1:0]);
                // byte or half inside the buffered half is fine
                HALF: trouble = (memop_data_type_i == WORD) ||
                                (entry_q[hit_idx].addr[1] != addr_i[1]);
                // full word holds every byte
                default: trouble = 1'b0;
            endcase
        end
    end

    // byte enables and lane placement of the incoming store
    always_comb begin
        case (memop_data_type_i)
            BYTE: begin
                wr_be    = 4'b0001 << addr_i[1:0];
                wr_lanes = {4{data_i[7:0]}};
            end
            HALF: begin
                wr_be    = addr_i[1] ? 4'b1100 : 4'b0011;
                wr_lanes = {2{data_i[15:0]}};
            end
            default: begin
                wr_be    = 4'b1111;
                wr_lanes = data_i;
            end
        endcase
    end

    assign do_merge = commit_i & is_store_i & hit & ~trouble;
    assign do_alloc = commit_i & is_store_i & ~hit & ~full_o;

    // tail drains unless a store merges into it on this same edge
    assign drain_valid_o = valid_q[tail_q] & ~(do_merge & (hit_idx == tail_q));
    assign do_drain      = drain_valid_o & flush_chance_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (do_drain) begin
                valid_q[tail_q] <= 1'b0;
                tail_q          <= next_ptr(tail_q);
            end
            // alloc never targets the draining slot, buffer is not full here
            if (do_alloc) begin
                valid_q[head_q] <= 1'b1;
                head_q          <= next_ptr(head_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_alloc) begin
            entry_q[head_q].addr     <= addr_i;
            entry_q[head_q].size     <= memop_data_type_i;
            entry_q[head_q].data     <= wr_lanes;
            entry_q[head_q].be       <= wr_be;
            entry_q[head_q].instr_id <= instr_id_i;
        end
        if (do_merge) begin
            // coalesce only the bytes this store writes
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    entry_q[hit_idx].data[b] <= wr_lanes[b];
                end
            end
            entry_q[hit_idx].be       <= entry_q[hit_idx].be | wr_be;
            entry_q[hit_idx].instr_id <= instr_id_i;
        end
    end

    assign hit_o       = hit;
    assign trouble_o   = trouble;
    assign full_o      = &valid_q;
    // whole word, lane selection happens in the stage
    assign load_data_o = entry_q[hit_idx].data;

    assign drain_o.word_addr = entry_q[tail_q].addr[`SEGRE_ADDR_SIZE-1:2];
    assign drain_o.be        = entry_q[tail_q].be;
    assign drain_o.data      = entry_q[tail_q].data;

endmodule

// ==== segre_data_mem.sv ====
`timescale 1ns/100ps
`include "segre_defs.svh"

module segre_data_mem import segre_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        wr_valid_i,
    input  sb_drain_t                   wr_i,
    input  logic [`SEGRE_ADDR_SIZE-3:0] rd_addr_i,
    output logic [`SEGRE_WORD_SIZE-1:0] rd_data_o
);

    localparam int WORDS = `SEGRE_DMEM_WORDS;
    localparam int IDX_W = $clog2(WORDS);

    // word array split into byte lanes
    logic [3:0][7:0]  mem_q [WORDS];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // upper address bits wrap onto the local array
    assign wr_idx = wr_i.word_addr[IDX_W-1:0];
    assign rd_idx = rd_addr_i[IDX_W-1:0];

    // byte-masked write from the store buffer drain
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (wr_valid_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_i.be[b]) begin
                    mem_q[wr_idx][b] <= wr_i.data[b*8 +: 8];
                end
            end
        end
    end

    // asynchronous read for loads that miss the buffer
    assign rd_data_o = mem_q[rd_idx];

endmodule

// ==== segre_mem_stage.sv ====
`timescale 1ns/100ps
`include "segre_defs.svh"

module segre_mem_stage import segre_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  mem_req_t req_i,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output mem_rsp_t rsp_o
);

    mem_req_t                    cur_req;
    logic                        cur_valid;
    logic                        cur_ready;
    logic                        stall;
    logic                        commit;
    logic                        flush_chance;
    logic                        rsp_in_ready;
    mem_rsp_t                    rsp_d;
    logic                        sb_hit;
    logic                        sb_full;
    logic                        sb_trouble;
    logic [`SEGRE_WORD_SIZE-1:0] sb_load_data;
    logic                        drain_valid;
    sb_drain_t                   drain;
    logic [`SEGRE_WORD_SIZE-1:0] mem_rd_data;
    logic [`SEGRE_WORD_SIZE-1:0] load_word;
    logic [`SEGRE_WORD_SIZE-1:0] load_shifted;
    logic [`SEGRE_WORD_SIZE-1:0] load_data;

    // current item of the stage
    segre_pipe_reg #(.payload_t(mem_req_t)) u_req_reg (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (req_valid_i),
        .in_ready_o (req_ready_o),
        .in_data_i  (req_i),
        .out_valid_o(cur_valid),
        .out_ready_i(cur_ready),
        .out_data_o (cur_req)
    );

    // stores wait on overlap or on a full buffer they cannot merge into
    assign stall = cur_req.is_store ? (sb_trouble | (sb_full & ~sb_hit)) : sb_trouble;

    // item leaves when free of stall and the response slot takes it
    assign cur_ready = ~stall & rsp_in_ready;
    assign commit    = cur_valid & cur_ready;

    // memory port is free unless a load misses the buffer
    assign flush_chance = ~(cur_valid & ~cur_req.is_store & ~sb_hit);

    segre_store_buffer u_store_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .lookup_valid_i   (cur_valid),
        .is_store_i       (cur_req.is_store),
        .commit_i         (commit),
        .addr_i           (cur_req.addr),
        .data_i           (cur_req.data),
        .memop_data_type_i(cur_req.memop_data_type),
        .instr_id_i       (cur_req.instr_id),
        .flush_chance_i   (flush_chance),
        .hit_o            (sb_hit),
        .full_o           (sb_full),
        .trouble_o        (sb_trouble),
        .load_data_o      (sb_load_data),
        .drain_valid_o    (drain_valid),
        .drain_o          (drain)
    );

    segre_data_mem u_data_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_valid_i(drain_valid & flush_chance),
        .wr_i      (drain),
        .rd_addr_i (cur_req.addr[`SEGRE_ADDR_SIZE-1:2]),
        .rd_data_o (mem_rd_data)
    );

    // buffered bytes win over memory, then pick the lanes and zero-extend
    always_comb begin
        load_word    = sb_hit ? sb_load_data : mem_rd_data;
        load_shifted = load_word >> {cur_req.addr[1:0], 3'b000};
        case (cur_req.memop_data_type)
            BYTE:    load_data = `SEGRE_WORD_SIZE'(load_shifted[7:0]);
            HALF:    load_data = `SEGRE_WORD_SIZE'(load_shifted[15:0]);
            default: load_data = load_word;
        endcase
        rsp_d.is_store  = cur_req.is_store;
        rsp_d.instr_id  = cur_req.instr_id;
        rsp_d.data      = cur_req.is_store ? '0 : load_data;
        rsp_d.forwarded = ~cur_req.is_store & sb_hit;
    end

    // response slot, back-pressure reaches the request side through cur_ready
    segre_pipe_reg #(.payload_t(mem_rsp_t)) u_rsp_reg (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_valid_i (cur_valid & ~stall),
        .in_ready_o (rsp_in_ready),
        .in_data_i  (rsp_d),
        .out_valid_o(rsp_valid_o),
        .out_ready_i(rsp_ready_i),
        .out_data_o (rsp_o)
    );

endmodule

// ==== segre_mem_stage_props.sv ====
`timescale 1ns/100ps
`include "segre_defs.svh"

module segre_mem_stage_props import segre_pkg::*; #(
    parameter int PTR_W = (`SEGRE_SB_ENTRIES > 1) ? $clog2(`SEGRE_SB_ENTRIES) : 1
) (
    input logic                         clk_i,
    input logic                         rst_n_i,
    input logic                         req_valid_i,
    input logic                         req_ready_i,
    input mem_req_t                     req_i,
    input logic                         rsp_valid_i,
    input logic                         rsp_ready_i,
    input mem_rsp_t                     rsp_i,
    input logic                         sb_full_i,
    input logic [`SEGRE_SB_ENTRIES-1:0] sb_valid_i,
    input logic [PTR_W-1:0]             sb_head_i,
    input logic [PTR_W-1:0]             sb_tail_i
);

    // requests taken minus responses handed out
    logic [2:0] in_flight_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_flight_q <= '0;
        end else begin
            in_flight_q <= in_flight_q + 3'(req_valid_i & req_ready_i)
                           - 3'(rsp_valid_i & rsp_ready_i);
        end
    end

    req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
        else $error("request payload moved before the transfer");

    rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else $error("response payload moved before the transfer");

    rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> in_flight_q != 0)
        else $error("response offered with no request outstanding");

    // tail always points at a live slot while anything is buffered
    // head meets tail again only once every slot is taken
    sb_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (sb_valid_i != '0) |->
            sb_valid_i[sb_tail_i] && ((sb_head_i == sb_tail_i) == sb_full_i))
        else $error("store buffer pointers disagree with its valid bits");

endmodule

bind segre_mem_stage segre_mem_stage_props u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_ready_i(req_ready_o),
    .req_i      (req_i),
    .rsp_valid_i(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_i      (rsp_o),
    .sb_full_i  (sb_full),
    .sb_valid_i (u_store_buffer.valid_q),
    .sb_head_i  (u_store_buffer.head_q),
    .sb_tail_i  (u_store_buffer.tail_q)
);

// ==== tb_segre_mem_stage.sv ====
`timescale 1ns/100ps
`include "segre_defs.svh"

module tb_segre_mem_stage import segre_pkg::*;;

    localparam int TIMEOUT = 200;

    logic     clk_i;
    logic     rst_n_i;
    logic     req_valid_i;
    logic     req_ready_o;
    mem_req_t req_i;
    logic     rsp_valid_o;
    logic     rsp_ready_i = 1'b1;
    mem_rsp_t rsp_o;
    logic     bp_en;

    // golden requests and their expected responses, in file order
    mem_req_t    req_q[$];
    logic [31:0] exp_data_q[$];
    logic        exp_fwd_q[$];

    segre_mem_stage uut (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // response side, random drops only while back-pressure is on
    always @(posedge clk_i) begin
        #2;
        rsp_ready_i = bp_en ? (($urandom % 3) != 0) : 1'b1;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_failure($sformatf("MISMATCH t=%0t %s got %h expected %h",
                                    $time, sig, got, exp));
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*128-1:0] line_buf;
        logic [31:0]      st;
        logic [31:0]      sz;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      id;
        logic [31:0]      exp_d;
        logic [31:0]      exp_f;
        mem_req_t         r;
        fd = $fopen("golden_vectors.txt", "r");
        if (fd == 0) stop_with_failure("could not open golden_vectors.txt");
        while (!$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            // comment and blank lines do not give seven fields
            n = $sscanf(line_buf, "%h %h %h %h %h %h %h", st, sz, addr, data, id, exp_d, exp_f);
            if (n == 7) begin
                r.is_store        = st[0];
                r.memop_data_type = memop_data_type_e'(sz[1:0]);
                r.addr            = addr;
                r.data            = data;
                r.instr_id        = id[`SEGRE_ID_SIZE-1:0];
                req_q.push_back(r);
                exp_data_q.push_back(exp_d);
                exp_fwd_q.push_back(exp_f[0]);
            end
        end
        $fclose(fd);
        if (req_q.size() == 0) stop_with_failure("golden file holds no vectors");
    endtask

    task automatic apply_reset();
        req_valid_i = 1'b0;
        rst_n_i     = 1'b0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
    endtask

    // hold valid and payload until the DUT takes the request
    task automatic send_request(input mem_req_t r);
        int waited;
        waited      = 0;
        req_i       = r;
        req_valid_i = 1'b1;
        @(negedge clk_i);
        while (!req_ready_o) begin
            waited++;
            if (waited > TIMEOUT) stop_with_failure("request was never accepted");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        req_valid_i = 1'b0;
    endtask

    task automatic issue_all();
        foreach (req_q[i]) send_request(req_q[i]);
    endtask

    task automatic check_response(input int i, input bit check_fwd);
        mem_req_t r;
        r = req_q[i];
        assert (rsp_o.is_store == r.is_store)
            else report_mismatch("rsp_o.is_store", 32'(rsp_o.is_store), 32'(r.is_store));
        assert (rsp_o.instr_id == r.instr_id)
            else report_mismatch("rsp_o.instr_id", 32'(rsp_o.instr_id), 32'(r.instr_id));
        assert (rsp_o.data == exp_data_q[i])
            else report_mismatch("rsp_o.data", rsp_o.data, exp_data_q[i]);
        // forwarding depends on drain timing, fixed only with no back-pressure
        if (check_fwd) begin
            assert (rsp_o.forwarded == exp_fwd_q[i])
                else report_mismatch("rsp_o.forwarded", 32'(rsp_o.forwarded),
                                     32'(exp_fwd_q[i]));
        end
    endtask

    // one transfer per negedge seen with valid and ready both high
    task automatic collect_responses(input bit check_fwd);
        int waited;
        for (int i = 0; i < req_q.size(); i++) begin
            waited = 0;
            @(negedge clk_i);
            while (!(rsp_valid_o && rsp_ready_i)) begin
                waited++;
                if (waited > TIMEOUT) stop_with_failure("response never arrived");
                @(negedge clk_i);
            end
            check_response(i, check_fwd);
        end
        repeat (4) begin
            @(negedge clk_i);
            assert (!rsp_valid_o) else stop_with_failure("extra response after the last one");
        end
    endtask

    initial begin
        void'($urandom(32'h3d4c));
        req_valid_i = 1'b0;
        req_i       = '0;
        rst_n_i     = 1'b0;
        bp_en       = 1'b0;
        load_vectors();
        // first run back to back with the response side always ready
        apply_reset();
        fork
            issue_all();
            collect_responses(1'b1);
        join
        // second run from a fresh reset under random back-pressure
        bp_en = 1'b1;
        @(posedge clk_i);
        #2;
        apply_reset();
        fork
            issue_all();
            collect_responses(1'b0);
        join
        $display("test passed");
        $finish;
    end

endmodule

// ==== golden_vectors.txt ====
// columns: store(1)/load(0), size (0 byte, 1 half, 2 word), byte address, store data,
// instr id, expected response data, expected forwarded flag (all hex)
1 2 00000010 a1b2c3d4 1 00000000 0
0 2 00000010 00000000 2 a1b2c3d4 1
1 2 00000020 11223344 3 00000000 0
1 0 00000021 000000ee 4 00000000 0
0 2 00000020 00000000 5 1122ee44 1
1 1 00000030 0000beef 6 00000000 0
1 2 00000030 12345678 7 00000000 0
1 2 00000040 cafe0001 8 00000000 0
0 2 00000030 00000000 9 12345678 0
1 2 00000050 0badf00d a 00000000 0
1 2 00000054 5eed1234 b 00000000 0
1 2 00000058 76543210 c 00000000 0
0 2 00000050 00000000 d 0badf00d 0
0 2 00000054 00000000 e 5eed1234 0
0 2 00000058 00000000 f 76543210 1
0 0 00000013 00000000 0 000000a1 0
0 1 00000022 00000000 1 00001122 0
1 1 00000062 00009a7c 2 00000000 0
0 0 00000063 00000000 3 0000009a 1
0 1 00000062 00000000 4 00009a7c 0
0 0 00000020 00000000 5 00000044 0

// ==== all.f ====
+incdir+.
segre_pkg.sv
segre_pipe_reg.sv
segre_store_buffer.sv
segre_data_mem.sv
segre_mem_stage.sv
segre_mem_stage_props.sv
tb_segre_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_segre_mem_stage \
    -f all.f -o Vtb_segre_mem_stage

./obj_dir/Vtb_segre_mem_stage 2>&1 | tee sim.log

grep -qx "test passed" sim.log
